//--- verilog/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 64;
  localparam int reg_addr_w = 5;

  // major opcode field, instr[6:0]
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_auipc  = 7'b0010111,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_op_32  = 7'b0111011,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_t;

  // one member per supported instruction
  typedef enum logic [4:0] {
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_beq,
    op_bne,
    op_addi,
    op_slti,
    op_slli,
    op_add,
    op_sub,
    op_addw,
    op_sllw,
    op_ld,
    op_lw,
    op_lbu,
    op_sh,
    op_sd,
    op_ebreak,
    op_illegal
  } op_kind;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_slt,
    alu_sll,
    alu_sllw
  } alu_op;

endpackage

//--- verilog/rv_decode.sv
module rv_decode (
  input  logic [31:0]                   instr,
  output rv_pkg::op_kind                op,
  output logic [rv_pkg::reg_addr_w-1:0] rd,
  output logic [rv_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_pkg::xlen-1:0]       imm_i,
  output logic [rv_pkg::xlen-1:0]       imm_s,
  output logic [rv_pkg::xlen-1:0]       imm_b,
  output logic [rv_pkg::xlen-1:0]       imm_u,
  output logic [rv_pkg::xlen-1:0]       imm_j,
  output logic [5:0]                    shamt
);
  import rv_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign rd    = instr[11:7];
  assign rs2   = instr[24:20];
  assign shamt = instr[25:20];

  // ebreak reads a0 for the exit flag
  assign rs1 = (op == op_ebreak) ? reg_addr_w'(10) : instr[19:15];

  assign imm_i = {{52{instr[31]}}, instr[31:20]};
  assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
  assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    op = op_illegal;
    case (instr[6:0])
      opc_lui: op = op_lui;
      opc_auipc: op = op_auipc;
      opc_jal: op = op_jal;
      opc_jalr: begin
        if (funct3 == 3'b000) op = op_jalr;
      end
      opc_branch: begin
        if (funct3 == 3'b000) op = op_beq;
        else if (funct3 == 3'b001) op = op_bne;
      end
      opc_op_imm: begin
        if (funct3 == 3'b000) op = op_addi;
        else if (funct3 == 3'b010) op = op_slti;
        // rv64 shift amount takes bit 25
        else if (funct3 == 3'b001 && instr[31:26] == 6'b0) op = op_slli;
      end
      opc_op: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) op = op_add;
        else if (funct3 == 3'b000 && funct7 == 7'b0100000) op = op_sub;
      end
      opc_op_32: begin
        if (funct7 == 7'b0000000) begin
          if (funct3 == 3'b000) op = op_addw;
          else if (funct3 == 3'b001) op = op_sllw;
        end
      end
      opc_load: begin
        if (funct3 == 3'b011) op = op_ld;
        else if (funct3 == 3'b010) op = op_lw;
        else if (funct3 == 3'b100) op = op_lbu;
      end
      opc_store: begin
        if (funct3 == 3'b001) op = op_sh;
        else if (funct3 == 3'b011) op = op_sd;
      end
      opc_system: begin
        if (instr == 32'h0010_0073) op = op_ebreak;
      end
      default: op = op_illegal;
    endcase
  end

endmodule

//--- verilog/rv_regfile.sv
module rv_regfile (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_pkg::xlen-1:0]       src1,
  output logic [rv_pkg::xlen-1:0]       src2,
  input  logic                          wen,
  input  logic [rv_pkg::reg_addr_w-1:0] waddr,
  input  logic [rv_pkg::xlen-1:0]       wdata
);
  import rv_pkg::*;

  localparam int num_regs = 1 << reg_addr_w;

  logic [xlen-1:0] regs [num_regs];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 hardwired
  assign src1 = (rs1 == '0) ? '0 : regs[rs1];
  assign src2 = (rs2 == '0) ? '0 : regs[rs2];

  // exec is expected to drop rd == x0 before it gets here
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    wen |-> waddr != '0
  );

endmodule

//--- verilog/rv_alu.sv
module rv_alu (
  input  rv_pkg::alu_op           mode,
  input  logic [rv_pkg::xlen-1:0] operand_a,
  input  logic [rv_pkg::xlen-1:0] operand_b,
  output logic [rv_pkg::xlen-1:0] result
);
  import rv_pkg::*;

  logic [31:0] shift_word;

  // word shift uses 5 bits of shift amount
  assign shift_word = operand_a[31:0] << operand_b[4:0];

  always_comb begin
    case (mode)
      alu_add: result = operand_a + operand_b;
      alu_sub: result = operand_a - operand_b;
      alu_slt: begin
        result = '0;
        result[0] = $signed(operand_a) < $signed(operand_b);
      end
      alu_sll: result = operand_a << operand_b[5:0];
      alu_sllw: result = {{32{shift_word[31]}}, shift_word};
      default: result = operand_a + operand_b;
    endcase
  end

endmodule

//--- verilog/rv_exec.sv
module rv_exec #(
  parameter int dmem_words = 64
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          instr_valid,
  input  rv_pkg::op_kind                op,
  input  logic [rv_pkg::reg_addr_w-1:0] rd,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  input  logic [rv_pkg::xlen-1:0]       imm_i,
  input  logic [rv_pkg::xlen-1:0]       imm_s,
  input  logic [rv_pkg::xlen-1:0]       imm_b,
  input  logic [rv_pkg::xlen-1:0]       imm_u,
  input  logic [rv_pkg::xlen-1:0]       imm_j,
  input  logic [5:0]                    shamt,
  output logic [rv_pkg::reg_addr_w-1:0] reg_raddr1,
  output logic [rv_pkg::reg_addr_w-1:0] reg_raddr2,
  input  logic [rv_pkg::xlen-1:0]       src1,
  input  logic [rv_pkg::xlen-1:0]       src2,
  output logic                          reg_wen,
  output logic [rv_pkg::reg_addr_w-1:0] reg_waddr,
  output logic [rv_pkg::xlen-1:0]       reg_wdata,
  output rv_pkg::alu_op                 alu_mode,
  output logic [rv_pkg::xlen-1:0]       operand_a,
  output logic [rv_pkg::xlen-1:0]       operand_b,
  input  logic [rv_pkg::xlen-1:0]       alu_result,
  output logic [rv_pkg::xlen-1:0]       mem_addr,
  input  logic [rv_pkg::xlen-1:0]       mem_rdata,
  output logic                          mem_we,
  output logic [rv_pkg::xlen-1:0]       mem_wdata,
  output logic [7:0]                    mem_wmask,
  output logic [rv_pkg::xlen-1:0]       pc,
  output logic                          halted,
  output logic                          exit_nonzero,
  output logic                          retire_valid,
  output logic [rv_pkg::xlen-1:0]       retire_pc,
  output logic                          retire_we,
  output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
  output logic [rv_pkg::xlen-1:0]       retire_wdata
);
  import rv_pkg::*;

  logic            accept;
  logic            writes_rd;
  logic            is_load;
  logic            taken;
  logic [xlen-1:0] snpc;
  logic [xlen-1:0] dnpc;
  logic [31:0]     load_word;
  logic [7:0]      load_byte;

  // strobes are dropped once halted
  assign accept = instr_valid && !halted;
  assign snpc = pc + xlen'(4);

  assign reg_raddr1 = rs1;
  assign reg_raddr2 = rs2;

  always_comb begin
    operand_a = src1;
    operand_b = src2;
    alu_mode = alu_add;
    case (op)
      op_lui: begin
        operand_a = '0;
        operand_b = imm_u;
      end
      op_auipc: begin
        operand_a = pc;
        operand_b = imm_u;
      end
      op_jal: begin
        operand_a = pc;
        operand_b = imm_j;
      end
      op_jalr, op_addi, op_ld, op_lw, op_lbu: operand_b = imm_i;
      op_slti: begin
        operand_b = imm_i;
        alu_mode = alu_slt;
      end
      op_slli: begin
        operand_b = {{(xlen-6){1'b0}}, shamt};
        alu_mode = alu_sll;
      end
      // branches compare through the subtractor
      op_sub, op_beq, op_bne: alu_mode = alu_sub;
      op_sllw: alu_mode = alu_sllw;
      op_sh, op_sd: operand_b = imm_s;
      default: alu_mode = alu_add;
    endcase
  end

  assign taken = (op == op_beq && alu_result == '0) || (op == op_bne && alu_result != '0);

  always_comb begin
    case (op)
      op_jal: dnpc = alu_result;
      op_jalr: dnpc = {alu_result[xlen-1:1], 1'b0};
      op_beq, op_bne: dnpc = taken ? pc + imm_b : snpc;
      default: dnpc = snpc;
    endcase
  end

  // load path, dmem returns the aligned doubleword
  assign mem_addr = alu_result;
  assign load_word = mem_addr[2] ? mem_rdata[63:32] : mem_rdata[31:0];
  assign load_byte = mem_rdata[{mem_addr[2:0], 3'b000} +: 8];

  always_comb begin
    case (op)
      op_jal, op_jalr: reg_wdata = snpc;
      op_addw, op_sllw: reg_wdata = {{32{alu_result[31]}}, alu_result[31:0]};
      op_ld: reg_wdata = mem_rdata;
      op_lw: reg_wdata = {{32{load_word[31]}}, load_word};
      op_lbu: reg_wdata = {{(xlen-8){1'b0}}, load_byte};
      default: reg_wdata = alu_result;
    endcase
  end

  assign is_load = op inside {op_ld, op_lw, op_lbu};
  assign writes_rd = !(op inside {op_beq, op_bne, op_sh, op_sd, op_ebreak, op_illegal});
  assign reg_wen = accept && writes_rd && rd != '0;
  assign reg_waddr = rd;

  // store data moved into its byte lanes
  assign mem_we = accept && (op inside {op_sh, op_sd});
  assign mem_wdata = (op == op_sh) ? src2 << {mem_addr[2:0], 3'b000} : src2;
  assign mem_wmask = (op == op_sh) ? 8'h03 << mem_addr[2:0] : 8'hff;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
      halted <= 1'b0;
      exit_nonzero <= 1'b0;
      retire_valid <= 1'b0;
      retire_we <= 1'b0;
    end else begin
      retire_valid <= accept;
      if (accept) begin
        pc <= dnpc;
        retire_we <= reg_wen;
        if (op == op_ebreak) begin
          halted <= 1'b1;
          exit_nonzero <= src1 != '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      retire_pc <= pc;
      retire_rd <= rd;
      retire_wdata <= reg_wdata;
    end
  end

  a_no_illegal: assert property (
    @(posedge clk) disable iff (!rst_n)
    accept |-> op != op_illegal
  );

  a_load_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    accept && is_load |-> (mem_addr >> 3) < dmem_words
  );

endmodule

//--- verilog/rv_dmem.sv
module rv_dmem #(
  parameter int dmem_words = 64
) (
  input  logic                    clk,
  input  logic [rv_pkg::xlen-1:0] mem_addr,
  output logic [rv_pkg::xlen-1:0] mem_rdata,
  input  logic                    mem_we,
  input  logic [rv_pkg::xlen-1:0] mem_wdata,
  input  logic [7:0]              mem_wmask
);
  import rv_pkg::*;

  localparam int idx_w = (dmem_words > 1) ? $clog2(dmem_words) : 1;

  logic [xlen-1:0]  mem [dmem_words];
  logic [idx_w-1:0] idx;

  // doubleword index, byte offset dropped
  assign idx = mem_addr[idx_w+2:3];

  assign mem_rdata = mem[idx];

  always_ff @(posedge clk) begin
    if (mem_we) begin
      for (int b = 0; b < 8; b++) begin
        if (mem_wmask[b]) begin
          mem[idx][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
    end
  end

  // upper address bits would alias otherwise
  a_write_in_range: assert property (
    @(posedge clk)
    mem_we |-> (mem_addr >> 3) < dmem_words
  );

endmodule

//--- verilog/rv_core.sv
module rv_core #(
  parameter int dmem_words = 64
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          instr_valid,
  input  logic [31:0]                   instr,
  output logic                          retire_valid,
  output logic [rv_pkg::xlen-1:0]       retire_pc,
  output logic                          retire_we,
  output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
  output logic [rv_pkg::xlen-1:0]       retire_wdata,
  output logic [rv_pkg::xlen-1:0]       pc,
  output logic                          halted,
  output logic                          exit_nonzero
);
  import rv_pkg::*;

  op_kind                op;
  logic [reg_addr_w-1:0] rd;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [xlen-1:0]       imm_i;
  logic [xlen-1:0]       imm_s;
  logic [xlen-1:0]       imm_b;
  logic [xlen-1:0]       imm_u;
  logic [xlen-1:0]       imm_j;
  logic [5:0]            shamt;
  logic [reg_addr_w-1:0] reg_raddr1;
  logic [reg_addr_w-1:0] reg_raddr2;
  logic [xlen-1:0]       src1;
  logic [xlen-1:0]       src2;
  logic                  reg_wen;
  logic [reg_addr_w-1:0] reg_waddr;
  logic [xlen-1:0]       reg_wdata;
  alu_op                 alu_mode;
  logic [xlen-1:0]       operand_a;
  logic [xlen-1:0]       operand_b;
  logic [xlen-1:0]       alu_result;
  logic [xlen-1:0]       mem_addr;
  logic [xlen-1:0]       mem_rdata;
  logic                  mem_we;
  logic [xlen-1:0]       mem_wdata;
  logic [7:0]            mem_wmask;

  rv_decode i_rv_decode (
    .instr (instr),
    .op    (op),
    .rd    (rd),
    .rs1   (rs1),
    .rs2   (rs2),
    .imm_i (imm_i),
    .imm_s (imm_s),
    .imm_b (imm_b),
    .imm_u (imm_u),
    .imm_j (imm_j),
    .shamt (shamt)
  );

  rv_exec #(
    .dmem_words (dmem_words)
  ) i_rv_exec (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .op           (op),
    .rd           (rd),
    .rs1          (rs1),
    .rs2          (rs2),
    .imm_i        (imm_i),
    .imm_s        (imm_s),
    .imm_b        (imm_b),
    .imm_u        (imm_u),
    .imm_j        (imm_j),
    .shamt        (shamt),
    .reg_raddr1   (reg_raddr1),
    .reg_raddr2   (reg_raddr2),
    .src1         (src1),
    .src2         (src2),
    .reg_wen      (reg_wen),
    .reg_waddr    (reg_waddr),
    .reg_wdata    (reg_wdata),
    .alu_mode     (alu_mode),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .alu_result   (alu_result),
    .mem_addr     (mem_addr),
    .mem_rdata    (mem_rdata),
    .mem_we       (mem_we),
    .mem_wdata    (mem_wdata),
    .mem_wmask    (mem_wmask),
    .pc           (pc),
    .halted       (halted),
    .exit_nonzero (exit_nonzero),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_we    (retire_we),
    .retire_rd    (retire_rd),
    .retire_wdata (retire_wdata)
  );

  rv_regfile i_rv_regfile (
    .clk   (clk),
    .rst_n (rst_n),
    .rs1   (reg_raddr1),
    .rs2   (reg_raddr2),
    .src1  (src1),
    .src2  (src2),
    .wen   (reg_wen),
    .waddr (reg_waddr),
    .wdata (reg_wdata)
  );

  rv_alu i_rv_alu (
    .mode      (alu_mode),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .result    (alu_result)
  );

  rv_dmem #(
    .dmem_words (dmem_words)
  ) i_rv_dmem (
    .clk       (clk),
    .mem_addr  (mem_addr),
    .mem_rdata (mem_rdata),
    .mem_we    (mem_we),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask)
  );

endmodule

//--- bench/tb_model.svh
`ifndef tb_model_svh
`define tb_model_svh

localparam logic [31:0] ebreak_word = 32'h0010_0073;

// shadow architectural state
logic [63:0] m_regs [32];
logic [63:0] m_mem [64];
logic [63:0] m_pc;
logic        m_halted;
logic        m_exit;

function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

// branch offset is in units of bytes, bit 0 dropped
function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

function automatic logic [63:0] widen_imm12(input logic [11:0] v);
  return {{52{v[11]}}, v};
endfunction

function automatic logic [63:0] widen_word(input logic [31:0] v);
  return {{32{v[31]}}, v};
endfunction

`endif

//--- bench/tb_core.sv
module tb_core;

  `include "tb_model.svh"

  localparam int n_fill = 62;
  localparam int n_arith = 63;
  localparam int n_mem_iters = 10;
  localparam int n_ctrl_iters = 10;
  localparam int n_strobes = n_fill + n_arith + 6 * n_mem_iters + 4 * n_ctrl_iters + 5;
  // two cycles per strobe, plus reset and slack
  localparam int timeout_cycles = 2 * n_strobes + 8 + 40;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic        retire_valid;
  logic [63:0] retire_pc;
  logic        retire_we;
  logic [4:0]  retire_rd;
  logic [63:0] retire_wdata;
  logic [63:0] pc;
  logic        halted;
  logic        exit_nonzero;

  logic        want_retire;
  logic [63:0] want_pc;
  logic        want_we;
  logic [4:0]  want_rd;
  logic [63:0] want_wdata;
  integer      seed = 32'h8427fde2;
  int          cycles = 0;

  rv_core #(
    .dmem_words (64)
  ) i_rv_core (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_we    (retire_we),
    .retire_rd    (retire_rd),
    .retire_wdata (retire_wdata),
    .pc           (pc),
    .halted       (halted),
    .exit_nonzero (exit_nonzero)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_failed();
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped on error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("Mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
    stop_failed();
  endtask

  a_reset_pc: assert property (@(posedge clk) !rst_n |-> pc == '0)
    else report_mismatch("pc", $sampled(pc), 64'h0);
  a_reset_flags: assert property (@(posedge clk)
    !rst_n |-> !retire_valid && !halted && !exit_nonzero)
    else report_mismatch("retire_valid/halted/exit_nonzero",
                         {$sampled(retire_valid), $sampled(halted), $sampled(exit_nonzero)}, 0);

  // one retire per accepted strobe, exactly one cycle later
  a_retire_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid == $past(want_retire))
    else report_mismatch("retire_valid", $sampled(retire_valid), !$sampled(retire_valid));
  a_retire_pc: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> retire_pc == want_pc)
    else report_mismatch("retire_pc", $sampled(retire_pc), want_pc);
  a_retire_we: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> retire_we == want_we)
    else report_mismatch("retire_we", $sampled(retire_we), want_we);
  a_retire_rd: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid && want_we |-> retire_rd == want_rd)
    else report_mismatch("retire_rd", $sampled(retire_rd), want_rd);
  a_retire_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid && want_we |-> retire_wdata == want_wdata)
    else report_mismatch("retire_wdata", $sampled(retire_wdata), want_wdata);
  // pc must also hold still once halted
  a_pc: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid || halted |-> pc == m_pc)
    else report_mismatch("pc", $sampled(pc), m_pc);
  a_halted: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> halted == m_halted)
    else report_mismatch("halted", $sampled(halted), m_halted);
  a_exit: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> exit_nonzero == m_exit)
    else report_mismatch("exit_nonzero", $sampled(exit_nonzero), m_exit);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
      stop_failed();
    end
  end

  task automatic reset_model();
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_pc = '0;
    m_halted = 1'b0;
    m_exit = 1'b0;
    want_retire = 1'b0;
    want_pc = '0;
    want_we = 1'b0;
    want_rd = '0;
    want_wdata = '0;
  endtask

  // one strobe, then an idle cycle while the retire is checked
  task automatic issue(input logic [31:0] word, input logic we, input logic [4:0] rd,
                       input logic [63:0] wdata, input logic [63:0] npc);
    @(negedge clk);
    instr = word;
    instr_valid = 1'b1;
    want_retire = !m_halted;
    if (!m_halted) begin
      want_pc = m_pc;
      want_we = we && rd != 5'd0;
      want_rd = rd;
      want_wdata = wdata;
      if (want_we) m_regs[rd] = wdata;
      m_pc = npc;
      if (word == ebreak_word) begin
        m_halted = 1'b1;
        m_exit = m_regs[10] != '0;
      end
    end
    @(negedge clk);
    instr_valid = 1'b0;
    want_retire = 1'b0;
  endtask

  task automatic fill_registers();
    logic [19:0] hi;
    logic [11:0] lo;
    for (int r = 1; r < 32; r++) begin
      hi = 20'($random(seed));
      lo = 12'($random(seed));
      issue(u_format(hi, 5'(r), 7'h37), 1'b1, 5'(r), widen_word({hi, 12'h0}), m_pc + 4);
      issue(i_format(lo, 5'(r), 3'b000, 5'(r), 7'h13), 1'b1, 5'(r),
            m_regs[r] + widen_imm12(lo), m_pc + 4);
    end
  endtask

  task automatic arith_sweep();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [19:0] up;
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] w;
    for (int i = 0; i < n_arith; i++) begin
      rs1 = 5'($random(seed));
      rs2 = 5'($random(seed));
      rd = (i % 8 == 0) ? 5'd0 : 5'($random(seed));
      imm = 12'($random(seed));
      up = 20'($random(seed));
      a = m_regs[rs1];
      b = m_regs[rs2];
      case (i % 9)
        0: issue(i_format(imm, rs1, 3'b000, rd, 7'h13), 1'b1, rd, a + widen_imm12(imm), m_pc + 4);
        1: issue(i_format(imm, rs1, 3'b010, rd, 7'h13), 1'b1, rd,
                 {63'h0, $signed(a) < $signed(widen_imm12(imm))}, m_pc + 4);
        2: issue(i_format({6'h0, imm[5:0]}, rs1, 3'b001, rd, 7'h13), 1'b1, rd,
                 a << imm[5:0], m_pc + 4);
        3: issue(r_format(7'h00, rs2, rs1, 3'b000, rd, 7'h33), 1'b1, rd, a + b, m_pc + 4);
        4: issue(r_format(7'h20, rs2, rs1, 3'b000, rd, 7'h33), 1'b1, rd, a - b, m_pc + 4);
        5: issue(u_format(up, rd, 7'h37), 1'b1, rd, widen_word({up, 12'h0}), m_pc + 4);
        6: issue(u_format(up, rd, 7'h17), 1'b1, rd, m_pc + widen_word({up, 12'h0}), m_pc + 4);
        7: begin
          w = a[31:0] + b[31:0];
          issue(r_format(7'h00, rs2, rs1, 3'b000, rd, 7'h3b), 1'b1, rd, widen_word(w), m_pc + 4);
        end
        default: begin
          w = a[31:0] << b[4:0];
          issue(r_format(7'h00, rs2, rs1, 3'b001, rd, 7'h3b), 1'b1, rd, widen_word(w), m_pc + 4);
        end
      endcase
    end
  endtask

  // x5 base, x6 and x7 store data, loads into x8, x9, x11
  task automatic memory_sweep();
    logic [63:0] base;
    logic [63:0] addr;
    logic [11:0] off;
    logic [1:0]  h;
    logic        wsel;
    logic [2:0]  bsel;
    logic [5:0]  idx;
    for (int i = 0; i < n_mem_iters; i++) begin
      base = 64'(8 * ({$random(seed)} % 48));
      off = 12'(8 * ({$random(seed)} % 15));
      h = 2'($random(seed));
      wsel = 1'($random(seed));
      bsel = 3'($random(seed));
      addr = base + widen_imm12(off);
      idx = addr[8:3];
      issue(i_format(base[11:0], 5'd0, 3'b000, 5'd5, 7'h13), 1'b1, 5'd5, base, m_pc + 4);
      issue(s_format(off, 5'd6, 5'd5, 3'b011), 1'b0, 5'd0, 64'h0, m_pc + 4);
      m_mem[idx] = m_regs[6];
      issue(s_format(off + 12'(2 * h), 5'd7, 5'd5, 3'b001), 1'b0, 5'd0, 64'h0, m_pc + 4);
      m_mem[idx][16*h +: 16] = m_regs[7][15:0];
      issue(i_format(off, 5'd5, 3'b011, 5'd8, 7'h03), 1'b1, 5'd8, m_mem[idx], m_pc + 4);
      issue(i_format(off + 12'(4 * wsel), 5'd5, 3'b010, 5'd9, 7'h03), 1'b1, 5'd9,
            widen_word(m_mem[idx][32*wsel +: 32]), m_pc + 4);
      issue(i_format(off + 12'(bsel), 5'd5, 3'b100, 5'd11, 7'h03), 1'b1, 5'd11,
            {56'h0, m_mem[idx][8*bsel +: 8]}, m_pc + 4);
    end
  endtask

  task automatic control_sweep();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [20:0] j_imm;
    logic [12:0] b_imm;
    logic [11:0] imm;
    logic [63:0] target;
    for (int i = 0; i < n_ctrl_iters; i++) begin
      rd = 5'($random(seed));
      rs1 = 5'($random(seed));
      j_imm = 21'($random(seed)) & ~21'h1;
      issue(j_format(j_imm, rd), 1'b1, rd, m_pc + 4, m_pc + {{43{j_imm[20]}}, j_imm});
      imm = 12'($random(seed));
      target = (m_regs[rs1] + widen_imm12(imm)) & ~64'h1;
      issue(i_format(imm, rs1, 3'b000, rd, 7'h67), 1'b1, rd, m_pc + 4, target);
      // equal operands half the time so both directions are taken
      rs2 = ($random(seed) & 1) ? rs1 : 5'($random(seed));
      b_imm = 13'($random(seed)) & ~13'h1;
      target = (m_regs[rs1] == m_regs[rs2]) ? m_pc + {{51{b_imm[12]}}, b_imm} : m_pc + 4;
      issue(b_format(b_imm, rs2, rs1, 3'b000), 1'b0, 5'd0, 64'h0, target);
      rs2 = ($random(seed) & 1) ? rs1 : 5'($random(seed));
      b_imm = 13'($random(seed)) & ~13'h1;
      target = (m_regs[rs1] != m_regs[rs2]) ? m_pc + {{51{b_imm[12]}}, b_imm} : m_pc + 4;
      issue(b_format(b_imm, rs2, rs1, 3'b001), 1'b0, 5'd0, 64'h0, target);
    end
  endtask

  task automatic halt_sequence();
    logic [11:0] a0_val;
    a0_val = 12'($random(seed) & 1);
    issue(i_format(a0_val, 5'd0, 3'b000, 5'd10, 7'h13), 1'b1, 5'd10,
          widen_imm12(a0_val), m_pc + 4);
    issue(ebreak_word, 1'b0, 5'd0, 64'h0, m_pc + 4);
    // these must be dropped by the halted core
    for (int i = 0; i < 3; i++) begin
      issue(i_format(12'($random(seed)), 5'd1, 3'b000, 5'd2, 7'h13), 1'b1, 5'd2,
            64'h0, m_pc + 4);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    reset_model();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    fill_registers();
    arith_sweep();
    memory_sweep();
    control_sweep();
    halt_sequence();
    repeat (4) @(negedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- list.f
+incdir+bench
verilog/rv_pkg.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_exec.sv
verilog/rv_dmem.sv
verilog/rv_core.sv
bench/tb_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_core
FILELIST  := list.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
